//--- hw/cacheGeomPkg.sv
`default_nettype none

// address geometry of the direct-mapped L1
// 52-bit tag, 6-bit index, offset handled outside the controller
package cacheGeomPkg;

    // upper address bits kept per line
    localparam int tagWidth = 52;

    // line select bits
    localparam int indexWidth = 6;

    // one tag and one valid bit per line
    localparam int numLines = 2 ** indexWidth;

    typedef logic [tagWidth-1:0] lineTag_t;

    typedef logic [indexWidth-1:0] lineIndex_t;

endpackage

`default_nettype wire

//--- hw/cacheCtrlPkg.sv
`default_nettype none

package cacheCtrlPkg;

    import cacheGeomPkg::*;

    // cpu side request, held until stall drops
    typedef struct packed {
        logic       read;
        logic       write;
        lineTag_t   tag;
        lineIndex_t index;
    } cacheReq_t;

    typedef enum logic [2:0] {
        idle,
        refill,
        update,
        writeThrough,
        flush
    } ctrlState_t;

    // controller outputs, unpacked to pins at the top
    typedef struct packed {
        logic stall;
        logic refill;
        logic update;
        logic readL2;
        logic writeL2;
    } ctrlStatus_t;

endpackage

`default_nettype wire

//--- hw/tagStore.sv
`timescale 1ns/1ps
`default_nettype none

module tagStore
    import cacheGeomPkg::*;
    import cacheCtrlPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  cacheReq_t  req,
    input  logic       tagWrite,
    input  logic       sweepClear,
    input  lineIndex_t sweepIndex,
    output logic       hit
);

    lineTag_t tagMem [numLines];
    logic [numLines-1:0] valid;

    lineTag_t storedTag;
    logic storedValid;

    // tags only mean something behind a set valid bit
    always_ff @(posedge clk)
    begin
        if (tagWrite)
        begin
            tagMem[req.index] <= req.tag;
        end
    end

    // all lines invalid after reset
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            valid <= '0;
        end
        else if (tagWrite)
        begin
            valid[req.index] <= 1'b1;
        end
        else if (sweepClear)
        begin
            valid[sweepIndex] <= 1'b0;
        end
    end

    // lookup at the requested line
    always_comb
    begin
        storedTag   = tagMem[req.index];
        storedValid = valid[req.index];
    end

    assign hit = storedValid && (storedTag == req.tag);

endmodule

`default_nettype wire

//--- hw/flushSweeper.sv
`timescale 1ns/1ps
`default_nettype none

module flushSweeper
    import cacheGeomPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       sweepStart,
    output lineIndex_t sweepIndex,
    output logic       sweepLast
);

    logic active;

    // one line per clock, starting from line 0
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            active     <= 1'b0;
            sweepIndex <= '0;
        end
        else if (sweepStart)
        begin
            active     <= 1'b1;
            sweepIndex <= '0;
        end
        else if (active)
        begin
            if (sweepLast)
            begin
                active <= 1'b0;
            end
            else
            begin
                sweepIndex <= sweepIndex + 1'b1;
            end
        end
    end

    // stops after the last line
    assign sweepLast = active && (sweepIndex == lineIndex_t'(numLines - 1));

endmodule

`default_nettype wire

//--- hw/l1Controller.sv
`timescale 1ns/1ps
`default_nettype none

module l1Controller
    import cacheCtrlPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  cacheReq_t   req,
    input  logic        hit,
    input  logic        readyL2,
    input  logic        flush,
    input  logic        sweepLast,
    output ctrlStatus_t status,
    output logic        tagWrite,
    output logic        sweepStart,
    output logic        sweepClear
);

    ctrlState_t state;
    ctrlState_t nextState;

    // set for the idle cycle right after a write-through,
    // so the pending write completes instead of starting again
    logic writeDone;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            state     <= idle;
            writeDone <= 1'b0;
        end
        else
        begin
            state     <= nextState;
            writeDone <= (state == writeThrough) && readyL2;
        end
    end

    always_comb
    begin
        nextState  = state;
        status     = '0;
        tagWrite   = 1'b0;
        sweepStart = 1'b0;
        sweepClear = 1'b0;

        case (state)
            idle:
            begin
                // flush only arrives with no request pending
                if (flush)
                begin
                    sweepStart = 1'b1;
                    nextState  = cacheCtrlPkg::flush;
                end
                else if (req.read && !hit)
                begin
                    status.stall = 1'b1;
                    nextState    = refill;
                end
                else if (req.write && !writeDone)
                begin
                    status.stall = 1'b1;
                    nextState    = writeThrough;
                end
            end

            refill:
            begin
                status.stall  = 1'b1;
                status.refill = 1'b1;
                status.readL2 = 1'b1;
                // line arrives, store the new tag
                if (readyL2)
                begin
                    tagWrite  = 1'b1;
                    nextState = update;
                end
            end

            update:
            begin
                status.stall  = 1'b1;
                status.update = 1'b1;
                nextState     = idle;
            end

            writeThrough:
            begin
                // no allocate, the tag store is left alone
                status.stall   = 1'b1;
                status.writeL2 = 1'b1;
                if (readyL2)
                begin
                    nextState = idle;
                end
            end

            cacheCtrlPkg::flush:
            begin
                status.stall = 1'b1;
                sweepClear   = 1'b1;
                if (sweepLast)
                begin
                    nextState = idle;
                end
            end

            default:
            begin
                nextState = idle;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/l1ControllerTop.sv
`timescale 1ns/1ps
`default_nettype none

module l1ControllerTop
    import cacheGeomPkg::*;
    import cacheCtrlPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [tagWidth-1:0]   tag,
    input  logic [indexWidth-1:0] index,
    input  logic                  readReq,
    input  logic                  writeReq,
    input  logic                  readyL2,
    input  logic                  flush,
    output logic                  stall,
    output logic                  refill,
    output logic                  update,
    output logic                  readL2,
    output logic                  writeL2
);

    cacheReq_t   cpuReq;
    ctrlStatus_t status;

    logic       hit;
    logic       tagWrite;
    logic       sweepStart;
    logic       sweepClear;
    logic       sweepLast;
    lineIndex_t sweepIndex;

    assign cpuReq = '{read: readReq, write: writeReq, tag: tag, index: index};

    l1Controller ctrl_i (
        .clk        (clk),
        .rstN       (rstN),
        .req        (cpuReq),
        .hit        (hit),
        .readyL2    (readyL2),
        .flush      (flush),
        .sweepLast  (sweepLast),
        .status     (status),
        .tagWrite   (tagWrite),
        .sweepStart (sweepStart),
        .sweepClear (sweepClear)
    );

    tagStore tags_i (
        .clk        (clk),
        .rstN       (rstN),
        .req        (cpuReq),
        .tagWrite   (tagWrite),
        .sweepClear (sweepClear),
        .sweepIndex (sweepIndex),
        .hit        (hit)
    );

    flushSweeper sweep_i (
        .clk        (clk),
        .rstN       (rstN),
        .sweepStart (sweepStart),
        .sweepIndex (sweepIndex),
        .sweepLast  (sweepLast)
    );

    // status bundle out to the cpu and L2 pins
    assign stall   = status.stall;
    assign refill  = status.refill;
    assign update  = status.update;
    assign readL2  = status.readL2;
    assign writeL2 = status.writeL2;

endmodule

`default_nettype wire

//--- verification/l1Controller_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module l1Controller_assertions
(
    input logic clk,
    input logic rstN,
    input logic update,
    input logic readL2,
    input logic writeL2,
    input logic readyL2
);

    // one L2 transfer at a time
    l2OneAtATime: assert property (@(posedge clk) disable iff (!rstN)
        !(readL2 && writeL2))
        else $error("readL2 and writeL2 high in the same cycle");

    updateOneCycle: assert property (@(posedge clk) disable iff (!rstN)
        update |=> !update)
        else $error("update high for more than one cycle");

    // refill request waits for L2
    readHeld: assert property (@(posedge clk) disable iff (!rstN)
        readL2 && !readyL2 |=> readL2)
        else $error("readL2 dropped before readyL2");

endmodule

bind l1ControllerTop l1Controller_assertions checks_i (
    .clk     (clk),
    .rstN    (rstN),
    .update  (update),
    .readL2  (readL2),
    .writeL2 (writeL2),
    .readyL2 (readyL2)
);

`default_nettype wire

//--- verification/l1ControllerTb.sv
`timescale 1ns/1ps
`default_nettype none

module l1ControllerTb
    import cacheGeomPkg::*;
();

    // one operation from the pattern file
    typedef struct packed {
        logic [7:0] op;
        lineTag_t   tag;
        lineIndex_t index;
        logic [7:0] latency;
        logic       expectHit;
    } patternLine_t;

    logic       clk = 1'b0;
    logic       rstN;
    lineTag_t   tag;
    lineIndex_t index;
    logic       readReq;
    logic       writeReq;
    logic       readyL2 = 1'b0;
    logic       flush;
    logic       stall;
    logic       refill;
    logic       update;
    logic       readL2;
    logic       writeL2;

    patternLine_t patterns[$];
    lineTag_t     refTag [numLines];
    logic         refValid [numLines] = '{default: 1'b0};
    int           maxLatency = 0;
    int           l2Latency = 0;
    int           waitCount = 0;
    logic         loaded = 1'b0;
    logic         runEnded = 1'b0;
    logic         failShown = 1'b0;

    l1ControllerTop dut_i (.*);

    always #20 clk = ~clk;

    // L2 model raises readyL2 once the latency of the current operation has passed
    always @(negedge clk)
    begin
        if (readyL2 || !rstN)
        begin
            readyL2   = 1'b0;
            waitCount = 0;
        end
        else if (readL2 || writeL2)
        begin
            if (waitCount >= l2Latency)
            begin
                readyL2 = 1'b1;
            end
            else
            begin
                waitCount++;
            end
        end
    end

    task automatic abortRun(input string reason);
        failShown = 1'b1;
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic expectEqual(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else abortRun($sformatf("ERR %s: got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // no request pending so every output is low
    task automatic checkIdle();
        expectEqual("{stall,refill,update,readL2,writeL2}",
                    {stall, refill, update, readL2, writeL2}, 0);
    endtask

    task automatic loadPatterns();
        int fd;
        int fields;
        string line;
        logic [7:0] op;
        logic [63:0] tagVal;
        int idxVal;
        int latVal;
        int hitVal;
        patternLine_t p;
        fd = $fopen("verification/l1Patterns.txt", "r");
        assert (fd != 0)
        else abortRun("could not open verification/l1Patterns.txt");
        while ($fgets(line, fd) > 0)
        begin
            if (line.len() < 2 || line.getc(0) == "#")
            begin
                continue;
            end
            fields = $sscanf(line, "%c %h %h %d %d", op, tagVal, idxVal, latVal, hitVal);
            assert (fields == 5)
            else abortRun({"malformed line in the pattern file: ", line});
            p.op        = op;
            p.tag       = lineTag_t'(tagVal);
            p.index     = lineIndex_t'(idxVal);
            p.latency   = 8'(latVal);
            p.expectHit = hitVal[0];
            patterns.push_back(p);
            if (latVal > maxLatency)
            begin
                maxLatency = latVal;
            end
        end
        $fclose(fd);
    endtask

    task automatic runAccess(input patternLine_t p);
        logic isRead;
        logic readMiss;
        logic l2Busy;
        int cycles;
        int lastL2Cycle;
        isRead      = (p.op == "R");
        readMiss    = isRead && !p.expectHit;
        cycles      = 0;
        lastL2Cycle = int'(p.latency) + 2;
        l2Latency   = int'(p.latency);
        @(negedge clk);
        tag      = p.tag;
        index    = p.index;
        readReq  = isRead;
        writeReq = !isRead;
        // request stays up until a cycle with stall low
        do
        begin
            @(posedge clk);
            cycles++;
            // L2 busy from the second cycle through the readyL2 cycle
            l2Busy = (cycles >= 2) && (cycles <= lastL2Cycle);
            if (cycles == 1)
            begin
                expectEqual("stall", stall, isRead ? !p.expectHit : 1'b1);
            end
            expectEqual("refill", refill, readMiss && l2Busy);
            expectEqual("readL2", readL2, readMiss && l2Busy);
            expectEqual("update", update, readMiss && cycles == lastL2Cycle + 1);
            expectEqual("writeL2", writeL2, !isRead && l2Busy);
        end
        while (stall);
        @(negedge clk);
        readReq  = 1'b0;
        writeReq = 1'b0;
        if (readMiss)
        begin
            expectEqual("stall (cycles)", cycles, p.latency + 4);
        end
        else if (isRead)
        begin
            expectEqual("stall (cycles)", cycles, 1);
        end
        else
        begin
            expectEqual("stall (cycles)", cycles, p.latency + 3);
        end
    endtask

    task automatic runFlush();
        int stallCycles;
        stallCycles = 0;
        @(negedge clk);
        flush = 1'b1;
        @(posedge clk);
        checkIdle();
        @(negedge clk);
        flush = 1'b0;
        @(posedge clk);
        while (stall)
        begin
            stallCycles++;
            expectEqual("{refill,update,readL2,writeL2}",
                        {refill, update, readL2, writeL2}, 0);
            @(posedge clk);
        end
        expectEqual("stall (flush cycles)", stallCycles, numLines);
    endtask

    task automatic runReset(input int cycles);
        rstN = 1'b0;
        repeat (cycles) @(posedge clk);
        checkIdle();
        @(negedge clk);
        rstN = 1'b1;
    endtask

    initial
    begin
        patternLine_t p;
        logic modelHit;
        rstN     = 1'b0;
        tag      = '0;
        index    = '0;
        readReq  = 1'b0;
        writeReq = 1'b0;
        flush    = 1'b0;
        void'($urandom(88));
        loadPatterns();
        loaded = 1'b1;
        runReset(10);
        foreach (patterns[i])
        begin
            p = patterns[i];
            modelHit = refValid[p.index] && refTag[p.index] == p.tag;
            case (p.op)
                "R", "W":
                begin
                    assert (modelHit == p.expectHit)
                    else abortRun($sformatf("pattern %0d disagrees with the tag history", i));
                    runAccess(p);
                    // reads allocate, writes never do
                    if (p.op == "R")
                    begin
                        refTag[p.index]   = p.tag;
                        refValid[p.index] = 1'b1;
                    end
                end
                "F":
                begin
                    runFlush();
                    refValid = '{default: 1'b0};
                end
                "X":
                begin
                    @(negedge clk);
                    runReset(3);
                    refValid = '{default: 1'b0};
                end
                default:
                begin
                    abortRun($sformatf("pattern %0d has an unknown operation code", i));
                end
            endcase
            repeat ($urandom_range(3, 0))
            begin
                @(posedge clk);
                checkIdle();
            end
        end
        runEnded = 1'b1;
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // budget grows with the pattern count and the slowest L2 answer
    initial
    begin
        int limit;
        wait (loaded);
        limit = patterns.size() * (maxLatency + numLines + 10) + 10;
        repeat (limit) @(posedge clk);
        abortRun($sformatf("timeout, the patterns did not finish within %0d cycles", limit));
    end

    // bound assertion stopped the run before the last pattern
    final
    begin
        if (!runEnded && !failShown)
        begin
            $display("CHECKS FAILED");
        end
    end

endmodule

`default_nettype wire

//--- verification/l1Patterns.txt
# op tag(hex) index(hex) l2Latency(cycles) expectHit
# R read, W write, F flush, X reset; F and X carry zero fields
R 00000000000a1 05 2 0
R 00000000000a1 05 0 1
R 00000000000b2 05 1 0
R 00000000000a1 05 3 0
R 00000000000a1 05 0 1
W 00000000000c3 10 2 0
R 00000000000c3 10 1 0
W 00000000000c3 10 0 1
R 00000000000c3 10 0 1
R fffffffffffff 3f 4 0
R 0000000000000 00 0 0
R fffffffffffff 3f 0 1
F 0000000000000 00 0 0
R 00000000000a1 05 1 0
R 00000000000c3 10 0 0
R fffffffffffff 3f 2 0
R 00000000000a1 05 0 1
W 123456789abcd 05 5 0
R 00000000000a1 05 0 1
X 0000000000000 00 0 0
R 00000000000a1 05 0 0
R 00000000000c3 10 2 0
R 00000000000a1 05 0 1
F 0000000000000 00 0 0
R 00000000000c3 10 0 0

//--- verilog.f
hw/cacheGeomPkg.sv
hw/cacheCtrlPkg.sv
hw/tagStore.sv
hw/flushSweeper.sv
hw/l1Controller.sv
hw/l1ControllerTop.sv
verification/l1Controller_assertions.sv
verification/l1ControllerTb.sv

//--- runSim.sh
#!/bin/sh
# build and run the L1 controller testbench from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module l1ControllerTb \
    -f verilog.f -Mdir obj_dir || exit 1

simOut=$(./obj_dir/Vl1ControllerTb 2>&1)
printf '%s\n' "$simOut"

printf '%s\n' "$simOut" | grep -qx "ALL CHECKS PASSED" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
